/* run_sim.sh */
#!/bin/bash
# build and run the ALU testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
log=sim.log

rm -f "$log" \
    && verilator --binary --timing --assert -f sim.f --top-module alu_tb -o alu_sim \
    && ./obj_dir/alu_sim +verilator+error+limit+1000 2>&1 | tee "$log" \
    || echo "build or simulation returned an error status"

grep -q "FAIL: see errors above" "$log" && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" "$log" || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0

/* sim.f */
source/alu_pkg.sv
source/alu_decode.sv
source/alu_execute.sv
source/alu_result.sv
source/alu_top.sv
test/alu_assert.sv
test/alu_tb.sv

/* source/alu_decode.sv */
/*
 * control-code register and decoder
 * produces the operation and the two operand selects
 */
module alu_decode
(
    input  logic                          alu_clk,
    input  logic                          alu_rst,
    input  logic [alu_pkg::ctrl_width-1:0] alu_ctrl_i,
    output alu_pkg::alu_op_e              op_o,
    output alu_pkg::opsel_a_e             sel_a_o,
    output alu_pkg::opsel_b_e             sel_b_o
);

    import alu_pkg::*;

    logic [ctrl_width-1:0] alu_ctrl_r;                  // code for the current cycle

    //////////////////////////////////////////////////
    // control register
    //////////////////////////////////////////////////
    always_ff @(posedge alu_clk or negedge alu_rst)
    begin
        if (!alu_rst)
        begin
            alu_ctrl_r <= '0;                           // idle code
        end
        else
        begin
            alu_ctrl_r <= alu_ctrl_i;
        end
    end

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////
    always_comb
    begin
        op_o    = op_none;                              // unknown codes fall through
        sel_a_o = sel_a_reg1;
        sel_b_o = sel_b_reg2;
        case (alu_ctrl_r)
            ctrl_add:
            begin
                op_o = op_add;
            end
            ctrl_addi, ctrl_addi16sp, ctrl_addi4spn:
            begin
                op_o    = op_add;
                sel_b_o = sel_b_imm;                    // sp offsets arrive as immediate
            end
            ctrl_sub:
            begin
                op_o = op_sub;
            end
            ctrl_and:
            begin
                op_o = op_and;
            end
            ctrl_andi:
            begin
                op_o    = op_and;
                sel_b_o = sel_b_imm;
            end
            ctrl_or:
            begin
                op_o = op_or;
            end
            ctrl_xor:
            begin
                op_o = op_xor;
            end
            ctrl_slli:
            begin
                op_o    = op_sll;
                sel_b_o = sel_b_imm;                    // shamt in imm
            end
            ctrl_srli:
            begin
                op_o    = op_srl;
                sel_b_o = sel_b_imm;
            end
            ctrl_srai:
            begin
                op_o    = op_sra;
                sel_b_o = sel_b_imm;
            end
            ctrl_li, ctrl_lui:
            begin
                op_o    = op_pass_b;
                sel_a_o = sel_a_zero;
                sel_b_o = sel_b_imm;                    // lui imm comes pre-shifted
            end
            ctrl_mv:
            begin
                op_o    = op_pass_b;
                sel_a_o = sel_a_zero;
            end
            ctrl_nop:
            begin
                op_o    = op_nop;
                sel_a_o = sel_a_zero;
                sel_b_o = sel_b_imm;
            end
            default:
            begin
                op_o = op_none;
            end
        endcase
    end

endmodule

/* source/alu_execute.sv */
/*
 * operand muxes, adder, subtractor, logic and shift units
 * result and carry select, zero-flag enable
 */
module alu_execute
(
    input  alu_pkg::alu_op_e               op_i,
    input  alu_pkg::opsel_a_e              sel_a_i,
    input  alu_pkg::opsel_b_e              sel_b_i,
    input  logic [alu_pkg::data_width-1:0] data_in_1_i,
    input  logic [alu_pkg::data_width-1:0] data_in_2_i,
    input  logic [alu_pkg::data_width-1:0] imm_val_i,
    output logic [alu_pkg::data_width-1:0] result_o,
    output logic                           carry_o,
    output logic                           zero_en_o
);

    import alu_pkg::*;

    logic [data_width-1:0]  oper_a;
    logic [data_width-1:0]  oper_b;
    logic [shamt_width-1:0] shamt;
    logic [data_width:0]    sum;                        // carry in msb
    logic [data_width:0]    diff;                       // borrow in msb
    logic [data_width-1:0]  and_res;
    logic [data_width-1:0]  or_res;
    logic [data_width-1:0]  xor_res;
    logic [data_width-1:0]  sll_res;
    logic [data_width-1:0]  srl_res;
    logic [data_width-1:0]  sra_res;

    //////////////////////////////////////////////////
    // operand select
    //////////////////////////////////////////////////
    always_comb
    begin
        if (sel_a_i == sel_a_zero)
        begin
            oper_a = '0;
        end
        else
        begin
            oper_a = data_in_1_i;
        end
    end

    always_comb
    begin
        if (sel_b_i == sel_b_imm)
        begin
            oper_b = imm_val_i;
        end
        else
        begin
            oper_b = data_in_2_i;
        end
    end

    //////////////////////////////////////////////////
    // functional units
    //////////////////////////////////////////////////
    assign sum     = {1'b0, oper_a} + {1'b0, oper_b};
    assign diff    = {1'b0, oper_a} - {1'b0, oper_b};  // msb set when B > A

    assign and_res = oper_a & oper_b;
    assign or_res  = oper_a | oper_b;
    assign xor_res = oper_a ^ oper_b;

    // upper bits of B are ignored for shifts
    assign shamt   = oper_b[shamt_width-1:0];
    assign sll_res = oper_a << shamt;
    assign srl_res = oper_a >> shamt;
    assign sra_res = $signed(oper_a) >>> shamt;        // sign fill from bit 31

    //////////////////////////////////////////////////
    // result and carry select
    //////////////////////////////////////////////////
    always_comb
    begin
        result_o = '0;
        carry_o  = 1'b0;                                // only add and sub produce carry
        case (op_i)
            op_add:
            begin
                result_o = sum[data_width-1:0];
                carry_o  = sum[data_width];
            end
            op_sub:
            begin
                result_o = diff[data_width-1:0];
                carry_o  = diff[data_width];
            end
            op_and:
            begin
                result_o = and_res;
            end
            op_or:
            begin
                result_o = or_res;
            end
            op_xor:
            begin
                result_o = xor_res;
            end
            op_sll:
            begin
                result_o = sll_res;
            end
            op_srl:
            begin
                result_o = srl_res;
            end
            op_sra:
            begin
                result_o = sra_res;
            end
            op_pass_b, op_nop:
            begin
                result_o = oper_b;                      // A is forced to 0 here
            end
            default:
            begin
                result_o = '0;                          // op_none
            end
        endcase
    end

    // nop and unknown codes never report zero
    assign zero_en_o = !(op_i inside {op_nop, op_none});

endmodule

/* source/alu_pkg.sv */
/*
 * shared widths, control-code values and the enumerations
 * for operation and operand select used across the ALU stage
 */
package alu_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int data_width  = 32;                    // operand and result
    localparam int ctrl_width  = 12;                    // control code from decode
    localparam int shamt_width = 5;                     // low bits of B used as shift amount

    //////////////////////////////////////////////////
    // control codes
    //////////////////////////////////////////////////
    // arithmetic, register and immediate forms
    localparam logic [ctrl_width-1:0] ctrl_add      = 12'b010000_1001_10;
    localparam logic [ctrl_width-1:0] ctrl_addi     = 12'b000000_1_000_01;
    localparam logic [ctrl_width-1:0] ctrl_addi16sp = 12'b00_00010_011_01;
    localparam logic [ctrl_width-1:0] ctrl_addi4spn = 12'b0000001_000_00;
    localparam logic [ctrl_width-1:0] ctrl_sub      = 12'b100_11_00_100_01;

    // bitwise logic
    localparam logic [ctrl_width-1:0] ctrl_and      = 12'b000_11_11_100_01;
    localparam logic [ctrl_width-1:0] ctrl_andi     = 12'b00000_10_100_01;
    localparam logic [ctrl_width-1:0] ctrl_or       = 12'b000_11_10_100_01;
    localparam logic [ctrl_width-1:0] ctrl_xor      = 12'b000_11_01_100_01;

    // shifts by immediate
    localparam logic [ctrl_width-1:0] ctrl_slli     = 12'b0000000_000_10;
    localparam logic [ctrl_width-1:0] ctrl_srli     = 12'b00000_00_100_01;
    localparam logic [ctrl_width-1:0] ctrl_srai     = 12'b00000_01_100_01;

    // moves and loads of the immediate
    localparam logic [ctrl_width-1:0] ctrl_li       = 12'b0000000_010_01;
    localparam logic [ctrl_width-1:0] ctrl_lui      = 12'b0000000_011_01;
    localparam logic [ctrl_width-1:0] ctrl_mv       = 12'b1_00000_0_100_10;
    localparam logic [ctrl_width-1:0] ctrl_nop      = 12'b0000_0_00000_01;

    // all-zero code is never issued, so it doubles as idle after reset

    //////////////////////////////////////////////////
    // decoded operation
    //////////////////////////////////////////////////
    typedef enum logic [3:0]
    {
        op_add    = 4'd0,                               // add and its immediate forms
        op_sub    = 4'd1,
        op_and    = 4'd2,
        op_or     = 4'd3,
        op_xor    = 4'd4,
        op_sll    = 4'd5,
        op_srl    = 4'd6,
        op_sra    = 4'd7,
        op_pass_b = 4'd8,                               // li, lui, mv
        op_nop    = 4'd9,                               // passes B, zero flag held low
        op_none   = 4'd10                               // unknown code, result 0
    } alu_op_e;

    //////////////////////////////////////////////////
    // operand selects
    //////////////////////////////////////////////////
    typedef enum logic
    {
        sel_a_reg1 = 1'b0,                              // source register 1
        sel_a_zero = 1'b1
    } opsel_a_e;

    typedef enum logic
    {
        sel_b_reg2 = 1'b0,                              // source register 2
        sel_b_imm  = 1'b1                               // decoded immediate
    } opsel_b_e;

endpackage

/* source/alu_result.sv */
/*
 * zero flag, stall gating of the forwarding path
 * and the registered data, carry and zero outputs
 */
module alu_result
(
    input  logic                           alu_clk,
    input  logic                           alu_rst,
    input  logic                           stall_i,
    input  logic [alu_pkg::data_width-1:0] result_i,
    input  logic                           carry_i,
    input  logic                           zero_en_i,
    output logic [alu_pkg::data_width-1:0] data_fwd_o,
    output logic [alu_pkg::data_width-1:0] data_out_o,
    output logic                           carry_o,
    output logic                           zero_o
);

    import alu_pkg::*;

    logic zero_flag;                                    // taken from the unstalled result

    //////////////////////////////////////////////////
    // flags and forwarding
    //////////////////////////////////////////////////
    assign zero_flag = zero_en_i && (result_i == {data_width{1'b0}});

    // stall only blanks the data value, flags still follow the operation
    always_comb
    begin
        if (stall_i)
        begin
            data_fwd_o = {data_width{1'b0}};
        end
        else
        begin
            data_fwd_o = result_i;
        end
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////
    always_ff @(posedge alu_clk or negedge alu_rst)
    begin
        if (!alu_rst)
        begin
            data_out_o <= {data_width{1'b0}};
            carry_o    <= 1'b0;
            zero_o     <= 1'b0;
        end
        else
        begin
            data_out_o <= data_fwd_o;                   // gated value
            carry_o    <= carry_i;
            zero_o     <= zero_flag;
        end
    end

endmodule

/* source/alu_top.sv */
/*
 * ALU stage top level: decode, execute and result
 */
module alu_top
(
    input  logic                           alu_clk,
    input  logic                           alu_rst,
    input  logic [alu_pkg::ctrl_width-1:0] alu_ctrl_i,
    input  logic                           stall_i,
    input  logic [alu_pkg::data_width-1:0] imm_val_i,
    input  logic [alu_pkg::data_width-1:0] data_in_1_i,
    input  logic [alu_pkg::data_width-1:0] data_in_2_i,
    output logic [alu_pkg::data_width-1:0] data_out_o,
    output logic [alu_pkg::data_width-1:0] data_fwd_o,
    output logic                           carry_o,
    output logic                           zero_o
);

    import alu_pkg::*;

    alu_op_e               op;                          // decode to execute
    opsel_a_e              sel_a;
    opsel_b_e              sel_b;
    logic [data_width-1:0] result;                      // execute to result
    logic                  carry;
    logic                  zero_en;

    //////////////////////////////////////////////////
    // pipeline blocks
    //////////////////////////////////////////////////
    alu_decode alu_decode_i
    (
        .alu_clk    (alu_clk),
        .alu_rst    (alu_rst),
        .alu_ctrl_i (alu_ctrl_i),
        .op_o       (op),
        .sel_a_o    (sel_a),
        .sel_b_o    (sel_b)
    );

    alu_execute alu_execute_i
    (
        .op_i        (op),
        .sel_a_i     (sel_a),
        .sel_b_i     (sel_b),
        .data_in_1_i (data_in_1_i),                     // operands lag the code by a cycle
        .data_in_2_i (data_in_2_i),
        .imm_val_i   (imm_val_i),
        .result_o    (result),
        .carry_o     (carry),
        .zero_en_o   (zero_en)
    );

    alu_result alu_result_i
    (
        .alu_clk    (alu_clk),
        .alu_rst    (alu_rst),
        .stall_i    (stall_i),
        .result_i   (result),
        .carry_i    (carry),
        .zero_en_i  (zero_en),
        .data_fwd_o (data_fwd_o),
        .data_out_o (data_out_o),
        .carry_o    (carry_o),
        .zero_o     (zero_o)
    );

endmodule

/* test/alu_assert.sv */
/*
 * reference model of the ALU stage and its concurrent assertions,
 * attached to alu_top by bind
 */
module alu_assert
(
    input  logic                           alu_clk,
    input  logic                           alu_rst,
    input  logic [alu_pkg::ctrl_width-1:0] alu_ctrl_i,
    input  logic                           stall_i,
    input  logic [alu_pkg::data_width-1:0] imm_val_i,
    input  logic [alu_pkg::data_width-1:0] data_in_1_i,
    input  logic [alu_pkg::data_width-1:0] data_in_2_i,
    input  logic [alu_pkg::data_width-1:0] data_out_i,
    input  logic [alu_pkg::data_width-1:0] data_fwd_i,
    input  logic                           carry_i,
    input  logic                           zero_i
);

    import alu_pkg::*;

    logic [ctrl_width-1:0]  ctrl_q;                     // code whose operands are on the bus
    logic [shamt_width-1:0] sh;
    logic [data_width-1:0]  exp_res;                    // unstalled result
    logic [data_width-1:0]  exp_fwd;
    logic                   exp_carry;
    logic                   exp_zero_en;
    logic                   code_valid;
    logic [data_width-1:0]  exp_out_q;                  // what the output register should hold
    logic                   exp_carry_q;
    logic                   exp_zero_q;
    logic                   idle_q;                     // no valid code has reached the outputs
    int unsigned            error_count = 0;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    assign sh = imm_val_i[shamt_width-1:0];             // shifts only take the immediate

    always_comb
    begin
        exp_res     = '0;
        exp_carry   = 1'b0;
        exp_zero_en = 1'b1;
        code_valid  = 1'b1;
        case (ctrl_q)
            ctrl_add: {exp_carry, exp_res} = {1'b0, data_in_1_i} + {1'b0, data_in_2_i};
            ctrl_addi, ctrl_addi16sp, ctrl_addi4spn:
                {exp_carry, exp_res} = {1'b0, data_in_1_i} + {1'b0, imm_val_i};
            ctrl_sub: {exp_carry, exp_res} = {1'b0, data_in_1_i} - {1'b0, data_in_2_i};
            ctrl_and: exp_res = data_in_1_i & data_in_2_i;
            ctrl_andi: exp_res = data_in_1_i & imm_val_i;
            ctrl_or: exp_res = data_in_1_i | data_in_2_i;
            ctrl_xor: exp_res = data_in_1_i ^ data_in_2_i;
            ctrl_slli: exp_res = data_in_1_i << sh;
            ctrl_srli: exp_res = data_in_1_i >> sh;
            ctrl_srai:                                  // logical shift plus sign fill on top
                exp_res = (data_in_1_i >> sh)
                        | (~({data_width{1'b1}} >> sh) & {data_width{data_in_1_i[data_width-1]}});
            ctrl_li, ctrl_lui: exp_res = imm_val_i;
            ctrl_mv: exp_res = data_in_2_i;
            ctrl_nop:
            begin
                exp_res     = imm_val_i;
                exp_zero_en = 1'b0;
            end
            default:
            begin
                exp_zero_en = 1'b0;                     // idle or unknown code
                code_valid  = 1'b0;
            end
        endcase
    end

    assign exp_fwd = stall_i ? '0 : exp_res;

    always_ff @(posedge alu_clk or negedge alu_rst)
    begin
        if (!alu_rst)
        begin
            ctrl_q      <= '0;
            exp_out_q   <= '0;
            exp_carry_q <= 1'b0;
            exp_zero_q  <= 1'b0;
            idle_q      <= 1'b1;
        end
        else
        begin
            ctrl_q      <= alu_ctrl_i;
            exp_out_q   <= exp_fwd;
            exp_carry_q <= exp_carry;
            exp_zero_q  <= exp_zero_en && (exp_res == '0);
            if (code_valid)
                idle_q <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // checks, sampled mid-cycle
    //////////////////////////////////////////////////
    fwd_chk: assert property (@(negedge alu_clk) disable iff (!alu_rst) data_fwd_i == exp_fwd)
        else
        begin
            error_count = error_count + 1;
            $error("MISMATCH t=%0t data_fwd_o got %h expected %h", $time, data_fwd_i, exp_fwd);
        end

    out_chk: assert property (@(negedge alu_clk) disable iff (!alu_rst) data_out_i == exp_out_q)
        else
        begin
            error_count = error_count + 1;
            $error("MISMATCH t=%0t data_out_o got %h expected %h", $time, data_out_i, exp_out_q);
        end

    carry_chk: assert property (@(negedge alu_clk) disable iff (!alu_rst) carry_i == exp_carry_q)
        else
        begin
            error_count = error_count + 1;
            $error("MISMATCH t=%0t carry_o got %b expected %b", $time, carry_i, exp_carry_q);
        end

    zero_chk: assert property (@(negedge alu_clk) disable iff (!alu_rst) zero_i == exp_zero_q)
        else
        begin
            error_count = error_count + 1;
            $error("MISMATCH t=%0t zero_o got %b expected %b", $time, zero_i, exp_zero_q);
        end

    idle_chk: assert property (@(negedge alu_clk) disable iff (!alu_rst)
                               idle_q |-> (data_out_i == '0 && !carry_i && !zero_i))
        else
        begin
            error_count = error_count + 1;
            $error("MISMATCH t=%0t idle data_out_o %h carry_o %b zero_o %b expected all 0",
                   $time, data_out_i, carry_i, zero_i);
        end

endmodule

bind alu_top alu_assert alu_assert_i
(
    .alu_clk     (alu_clk),
    .alu_rst     (alu_rst),
    .alu_ctrl_i  (alu_ctrl_i),
    .stall_i     (stall_i),
    .imm_val_i   (imm_val_i),
    .data_in_1_i (data_in_1_i),
    .data_in_2_i (data_in_2_i),
    .data_out_i  (data_out_o),
    .data_fwd_i  (data_fwd_o),
    .carry_i     (carry_o),
    .zero_i      (zero_o)
);

/* test/alu_tb.sv */
/*
 * ALU stage testbench: clock, reset, directed and LFSR stimulus,
 * watchdog and pass/fail reporting
 */
module alu_tb;

    import alu_pkg::*;

    localparam int clk_period   = 10;
    localparam int reset_cycles = 10;
    localparam int directed_ops = 24;
    localparam int random_ops   = 400;
    localparam int drain_ops    = 3;
    localparam int timeout      =
        (reset_cycles + 3 + directed_ops + random_ops + drain_ops + 100) * clk_period;

    localparam logic [ctrl_width-1:0] code_list [16] = '{
        ctrl_add, ctrl_addi, ctrl_addi16sp, ctrl_addi4spn, ctrl_sub, ctrl_and, ctrl_andi,
        ctrl_or, ctrl_xor, ctrl_slli, ctrl_srli, ctrl_srai, ctrl_li, ctrl_lui, ctrl_mv, ctrl_nop
    };

    logic                  alu_clk = 1'b0;
    logic                  alu_rst;
    logic [ctrl_width-1:0] alu_ctrl_i;
    logic                  stall_i;
    logic [data_width-1:0] imm_val_i;
    logic [data_width-1:0] data_in_1_i;
    logic [data_width-1:0] data_in_2_i;
    logic [data_width-1:0] data_out_o;
    logic [data_width-1:0] data_fwd_o;
    logic                  carry_o;
    logic                  zero_o;

    logic [data_width-1:0] pend_r1;                     // operands of the code issued last cycle
    logic [data_width-1:0] pend_r2;
    logic [data_width-1:0] pend_imm;
    logic                  pend_stall;
    logic [31:0]           lfsr_state = 32'd76;

    always #(clk_period / 2) alu_clk = ~alu_clk;

    alu_top alu_top_i
    (
        .alu_clk     (alu_clk),
        .alu_rst     (alu_rst),
        .alu_ctrl_i  (alu_ctrl_i),
        .stall_i     (stall_i),
        .imm_val_i   (imm_val_i),
        .data_in_1_i (data_in_1_i),
        .data_in_2_i (data_in_2_i),
        .data_out_o  (data_out_o),
        .data_fwd_o  (data_fwd_o),
        .carry_o     (carry_o),
        .zero_o      (zero_o)
    );

    //////////////////////////////////////////////////
    // random source
    //////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;            // taps 32, 22, 2, 1
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    // code goes out now, its operands and stall one cycle later
    task automatic issue_op(input logic [ctrl_width-1:0] code, input logic [data_width-1:0] r1,
                            input logic [data_width-1:0] r2, input logic [data_width-1:0] imm,
                            input logic stall);
        @(posedge alu_clk);
        #1;
        alu_ctrl_i  = code;
        data_in_1_i = pend_r1;
        data_in_2_i = pend_r2;
        imm_val_i   = pend_imm;
        stall_i     = pend_stall;
        pend_r1     = r1;
        pend_r2     = r2;
        pend_imm    = imm;
        pend_stall  = stall;
    endtask

    task automatic issue_random();
        logic [3:0]            idx;
        logic [ctrl_width-1:0] code;
        logic [data_width-1:0] r1;
        logic [data_width-1:0] r2;
        logic [data_width-1:0] imm;
        logic                  stall;
        idx = 4'(take_bits(4));
        if (take_bits(3) == 0)
            code = ctrl_width'(take_bits(ctrl_width)); // mostly invalid codes
        else
            code = code_list[idx];
        r1 = take_bits(32);
        r2 = take_bits(32);
        imm = take_bits(32);
        if (take_bits(3) == 0)
            r2 = r1;                                    // equal operands for zero results
        if (take_bits(3) == 0)
            imm = '0;
        stall = (take_bits(2) == 0);
        issue_op(code, r1, r2, imm, stall);
    endtask

    task automatic run_directed();
        issue_op(ctrl_add, 32'h0, 32'h0, 32'h0, 1'b0);  // zero sum
        issue_op(ctrl_add, 32'hffff_ffff, 32'h1, 32'h0, 1'b0);
        issue_op(ctrl_add, 32'h8000_0000, 32'h8000_0001, 32'h0, 1'b0);
        issue_op(ctrl_addi, 32'h7fff_ffff, 32'h5, 32'h1, 1'b0);
        issue_op(ctrl_addi16sp, 32'h10, 32'h0, 32'hffff_fff0, 1'b0);
        issue_op(ctrl_addi4spn, 32'h100, 32'h9, 32'h24, 1'b0);
        issue_op(ctrl_sub, 32'h1, 32'h2, 32'h0, 1'b0);  // borrow
        issue_op(ctrl_sub, 32'h1234, 32'h1234, 32'h0, 1'b0);
        issue_op(ctrl_sub, 32'h5, 32'h3, 32'h7, 1'b0);
        issue_op(ctrl_and, 32'hf0f0_f0f0, 32'h0f0f_0f0f, 32'h0, 1'b0);
        issue_op(ctrl_andi, 32'hdead_beef, 32'h0, 32'h0000_ffff, 1'b0);
        issue_op(ctrl_or, 32'ha5a5_0000, 32'h0000_5a5a, 32'h0, 1'b0);
        issue_op(ctrl_xor, 32'h1234_5678, 32'h1234_5678, 32'h0, 1'b0);
        issue_op(ctrl_slli, 32'h1, 32'h0, 32'd31, 1'b0);
        issue_op(ctrl_srli, 32'h8000_0000, 32'h0, 32'h3f, 1'b0);
        issue_op(ctrl_srai, 32'h8000_0000, 32'h0, 32'd4, 1'b0);
        issue_op(ctrl_srai, 32'h7fff_fff0, 32'h0, 32'd4, 1'b0);
        issue_op(ctrl_li, 32'h55, 32'h66, 32'h0, 1'b0);
        issue_op(ctrl_lui, 32'h55, 32'h66, 32'h1234_5000, 1'b0);
        issue_op(ctrl_mv, 32'h55, 32'h0, 32'h77, 1'b0);
        issue_op(ctrl_nop, 32'hff, 32'hff, 32'h0, 1'b0); // zero flag stays low
        issue_op(12'hfff, 32'h1, 32'h2, 32'h3, 1'b0);
        issue_op(ctrl_add, 32'h5, 32'h6, 32'h0, 1'b1);
        issue_op(ctrl_sub, 32'h3, 32'h3, 32'h0, 1'b1);  // zero flag despite stall
    endtask

    //////////////////////////////////////////////////
    // sequence and end of run
    //////////////////////////////////////////////////
    initial
    begin
        alu_rst     = 1'b0;
        alu_ctrl_i  = '0;
        stall_i     = 1'b0;
        imm_val_i   = '0;
        data_in_1_i = '0;
        data_in_2_i = '0;
        pend_r1     = '0;
        pend_r2     = '0;
        pend_imm    = '0;
        pend_stall  = 1'b0;
        repeat (reset_cycles) @(posedge alu_clk);
        #1;
        alu_rst = 1'b1;
        repeat (3) issue_op('0, '0, '0, '0, 1'b0); // idle after reset
        run_directed();
        repeat (random_ops) issue_random();
        repeat (drain_ops) issue_op('0, '0, '0, '0, 1'b0);
        repeat (2) @(posedge alu_clk);
        if (alu_top_i.alu_assert_i.error_count != 0)
        begin
            $display("FAIL: see errors above");
            $fatal(1, "assertion failures recorded during the run");
        end
        else
        begin
            $display("PASS: all tests");
            $finish;
        end
    end

    always @(posedge alu_clk)
    begin
        if (alu_top_i.alu_assert_i.error_count != 0)
        begin
            $display("FAIL: see errors above");
            $fatal(1, "stopping at the first assertion failure");
        end
    end

    initial
    begin
        #(timeout);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired before the test sequence finished");
    end

endmodule
